//--- filelist.f
+incdir+source
+incdir+verification
source/psum_reduce_pkg.sv
source/psum_decode.sv
source/psum_reduce_tree.sv
source/psum_pack_write.sv
source/psum_reduce_top.sv
verification/psum_reduce_tb.sv

//--- Bender.yml
package:
  name: psum_reduce

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/psum_reduce_pkg.sv
      - source/psum_decode.sv
      - source/psum_reduce_tree.sv
      - source/psum_pack_write.sv
      - source/psum_reduce_top.sv

  - target: test
    include_dirs:
      - source
      - verification
    files:
      - verification/psum_reduce_tb.sv

//--- verification/psum_reduce_checks.svh
//--------------------------------------
// psum reduction reference model
// expected words and addresses, typed compares
//--------------------------------------
`ifndef PSUM_REDUCE_CHECKS_SVH
`define PSUM_REDUCE_CHECKS_SVH

psum_reduce_pkg::fold_mode_e    model_mode  = psum_reduce_pkg::fold_1;
int                             model_count = 1;
int                             model_fill  = 0;    // next lane to fill
int                             model_addr  = 0;
psum_reduce_pkg::buf_word_t     model_word  = '0;
psum_reduce_pkg::buf_word_t     exp_words[$];
psum_reduce_pkg::buf_addr_t     exp_addrs[$];

function automatic int fold_factor(input psum_reduce_pkg::fold_mode_e m);
    case (m)
        psum_reduce_pkg::fold_2: return 2;
        psum_reduce_pkg::fold_4: return 4;
        default:                 return 1;
    endcase
endfunction

// sum j covers every column of rows j*f .. j*f+f-1, wrapping at 16 bits
function automatic psum_reduce_pkg::row_sums_t fold_frame(
    input psum_reduce_pkg::psum_frame_t f, input psum_reduce_pkg::fold_mode_e m);
    psum_reduce_pkg::row_sums_t sums;
    int                         fold;
    sums = '0;
    fold = fold_factor(m);
    for (int j = 0; j < `PSUM_ROWS / fold; j++)
        for (int r = j * fold; r < (j + 1) * fold; r++)
            for (int c = 0; c < `PSUM_COLS; c++)
                sums[j] = sums[j] + f[r][c];
    return sums;
endfunction

task automatic model_config(input psum_reduce_pkg::fold_mode_e mode, input int count);
    model_mode  = mode;
    model_count = count;
    model_fill  = 0;    // partial word is gone
    model_addr  = 0;
    model_word  = '0;
endtask

task automatic model_frame(input psum_reduce_pkg::psum_frame_t f, output bit completes);
    psum_reduce_pkg::row_sums_t sums;
    int                         per_frame;
    sums      = fold_frame(f, model_mode);
    per_frame = `PSUM_ROWS / fold_factor(model_mode);
    for (int j = 0; j < per_frame; j++)
        model_word[model_fill + j] = sums[j];
    model_fill = model_fill + per_frame;
    completes  = 1'b0;
    if (model_fill == `BUF_LANES) begin
        exp_words.push_back(model_word);
        exp_addrs.push_back(psum_reduce_pkg::buf_addr_t'(model_addr));
        model_fill = 0;
        model_addr = (model_addr + 1 >= model_count) ? 0 : model_addr + 1;
        completes  = 1'b1;
    end
endtask

task automatic check_word(input string name, input psum_reduce_pkg::buf_word_t got,
                          input psum_reduce_pkg::buf_word_t exp);
    if (got !== exp)
        stop_on_error($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp));
endtask

task automatic check_addr(input string name, input psum_reduce_pkg::buf_addr_t got,
                          input psum_reduce_pkg::buf_addr_t exp);
    if (got !== exp)
        stop_on_error($sformatf("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp));
endtask

task automatic check_strobe(input string name, input logic got, input logic exp);
    if (got !== exp)
        stop_on_error($sformatf("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp));
endtask

`endif

//--- verification/psum_reduce_tb.sv
//--------------------------------------
// psum reduction testbench
// random frames against a word model, write timing monitor
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "psum_reduce_params.svh"

module psum_reduce_tb;

    localparam int MAX_GAP      = 3;    // idle cycles between frames, 0 means back to back
    localparam int N_DEFAULTS   = 4;    // fold_1 out of reset, limit 1
    localparam int N_FOLD1      = 6;
    localparam int N_FOLD2      = 12;
    localparam int N_FOLD4      = 16;   // 15 random plus one all-ones frame
    localparam int N_WRAP       = 10;   // 5 words over a count of 3
    localparam int N_DISCARD    = 15;   // 4 + 3 partial, then 8 after the change
    localparam int N_BURST      = 16;
    localparam int N_CONFIGS    = 7;
    localparam int TOTAL_FRAMES = N_DEFAULTS + N_FOLD1 + N_FOLD2 + N_FOLD4 + N_WRAP
                                  + N_DISCARD + N_BURST;
    // a word takes 2, 4 or 8 frames for fold 1, 2 or 4
    localparam int N_WORDS      = (N_DEFAULTS + N_FOLD1 + N_WRAP) / 2
                                  + (N_FOLD2 + N_BURST) / 4 + N_FOLD4 / 8
                                  + 1 + (N_DISCARD - 7) / 8;
    localparam int WATCHDOG_CYCLES = 16 + TOTAL_FRAMES * (MAX_GAP + 1) + N_CONFIGS * 6
                                     + 8 * 8 + 200;

    logic                               clk = 1'b0;
    logic                               reset;
    logic                               cfg_valid;
    psum_reduce_pkg::fold_mode_e        cfg_mode;
    psum_reduce_pkg::buf_addr_t         cfg_word_count;
    logic                               psum_valid;
    psum_reduce_pkg::psum_frame_t       psum_frame;
    logic                               wr_en;
    psum_reduce_pkg::buf_addr_t         wr_addr;
    psum_reduce_pkg::buf_word_t         wr_data;

    logic                               frame_done;         // driven frame completes a word
    logic [2:0]                         done_pipe = '0;     // completion seen 1..3 edges ago
    logic [31:0]                        lcg_state = 32'd23;
    int                                 writes_seen = 0;
    psum_reduce_pkg::buf_addr_t         seen_addrs[$];

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "psum_reduce_checks.svh"

    psum_reduce_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .cfg_valid      (cfg_valid),
        .cfg_mode       (cfg_mode),
        .cfg_word_count (cfg_word_count),
        .psum_valid     (psum_valid),
        .psum_frame     (psum_frame),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic psum_reduce_pkg::psum_frame_t random_frame();
        psum_reduce_pkg::psum_frame_t f;
        logic [31:0]                  r;
        for (int row = 0; row < `PSUM_ROWS; row++) begin
            for (int col = 0; col < `PSUM_COLS; col++) begin
                r = next_rand();
                f[row][col] = r[31:16];     // upper bits, the low ones cycle quickly
            end
        end
        return f;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            cfg_valid  <= 1'b0;
            psum_valid <= 1'b0;
            frame_done <= 1'b0;
        end
    endtask

    task automatic send_frame(input psum_reduce_pkg::psum_frame_t f);
        bit completes;
        @(posedge clk);
        model_frame(f, completes);
        cfg_valid  <= 1'b0;
        psum_valid <= 1'b1;
        psum_frame <= f;
        frame_done <= completes;
    endtask

    task automatic run_frames(input int count, input bit gaps);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            send_frame(random_frame());
            if (gaps) begin
                r = next_rand();
                idle_cycles(int'(r[25:24]));
            end
        end
    endtask

    // pipeline must be quiet for 3 cycles before a configuration strobe
    task automatic configure(input psum_reduce_pkg::fold_mode_e mode, input int count);
        idle_cycles(4);
        @(posedge clk);
        model_config(mode, count);
        cfg_valid      <= 1'b1;
        cfg_mode       <= mode;
        cfg_word_count <= psum_reduce_pkg::buf_addr_t'(count);
        psum_valid     <= 1'b0;
        frame_done     <= 1'b0;
        idle_cycles(1);
    endtask

    task automatic wait_drained();
        while (exp_words.size() != 0)
            idle_cycles(1);
        idle_cycles(4);     // room for a stray write to show up
    endtask

    // write monitor, wr_en must follow a completing frame by exactly 3 edges
    always @(posedge clk) begin
        if (!reset) begin
            check_strobe("wr_en", wr_en, done_pipe[2]);
            if (wr_en) begin
                if (exp_words.size() == 0) begin
                    stop_on_error($sformatf("write at %0t ns with no word expected", $time));
                end else begin
                    check_addr("wr_addr", wr_addr, exp_addrs.pop_front());
                    check_word("wr_data", wr_data, exp_words.pop_front());
                    seen_addrs.push_back(wr_addr);
                    writes_seen++;
                end
            end
        end
        done_pipe <= {done_pipe[1:0], psum_valid & frame_done};
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("timeout after %0d cycles, the run did not finish",
                                WATCHDOG_CYCLES));
    end

    initial begin : stimulus
        cfg_valid      <= 1'b0;
        cfg_mode       <= psum_reduce_pkg::fold_1;
        cfg_word_count <= psum_reduce_pkg::buf_addr_t'(1);
        psum_valid     <= 1'b0;
        psum_frame     <= '0;
        frame_done     <= 1'b0;
        reset          <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        run_frames(N_DEFAULTS, 1'b1);   // reset defaults, every word lands at 0
        wait_drained();
        configure(psum_reduce_pkg::fold_1, 8);
        run_frames(N_FOLD1, 1'b1);
        wait_drained();

        configure(psum_reduce_pkg::fold_2, 16);
        run_frames(N_FOLD2, 1'b1);
        wait_drained();

        // 64 full-scale values per quad sum wrap well past 2^16
        configure(psum_reduce_pkg::fold_4, 5);
        run_frames(7, 1'b1);
        send_frame('1);
        run_frames(N_FOLD4 - 8, 1'b1);
        wait_drained();

        configure(psum_reduce_pkg::fold_1, 3);
        seen_addrs.delete();
        run_frames(N_WRAP, 1'b1);
        wait_drained();
        if (seen_addrs.size() != 5)
            stop_on_error($sformatf("word count 3 gave %0d writes instead of 5",
                                    seen_addrs.size()));
        for (int i = 0; i < 5; i++)
            check_addr("wr_addr", seen_addrs[i], psum_reduce_pkg::buf_addr_t'(i % 3));

        // three frames of a partial word are dropped by the reconfiguration
        configure(psum_reduce_pkg::fold_2, 4);
        run_frames(7, 1'b1);
        configure(psum_reduce_pkg::fold_4, 2);
        run_frames(N_DISCARD - 7, 1'b1);
        wait_drained();

        configure(psum_reduce_pkg::fold_2, 7);
        run_frames(N_BURST, 1'b0);
        wait_drained();

        if (writes_seen == N_WORDS) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stop_on_error($sformatf("run ended with %0d of %0d writes seen",
                                    writes_seen, N_WORDS));
        end
    end

endmodule

`default_nettype wire

//--- source/psum_reduce_top.sv
//--------------------------------------
// psum reduction top
// decode, reduce tree and pack/write stages
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module psum_reduce_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cfg_valid,
    input  psum_reduce_pkg::fold_mode_e      cfg_mode,
    input  psum_reduce_pkg::buf_addr_t       cfg_word_count,
    input  logic                             psum_valid,
    input  psum_reduce_pkg::psum_frame_t     psum_frame,
    output logic                             wr_en,
    output psum_reduce_pkg::buf_addr_t       wr_addr,
    output psum_reduce_pkg::buf_word_t       wr_data
);

    // decode -> execute
    wire                                 dec_valid;
    wire psum_reduce_pkg::psum_frame_t   dec_frame;
    wire psum_reduce_pkg::fold_mode_e    dec_mode;

    // decode -> result, configuration side
    wire psum_reduce_pkg::buf_addr_t     word_limit;
    wire                                 cfg_clear;

    // execute -> result
    wire                                 exe_valid;
    wire psum_reduce_pkg::row_sums_t     exe_sums;
    wire psum_reduce_pkg::fold_mode_e    exe_mode;

    psum_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .cfg_valid      (cfg_valid),
        .cfg_mode       (cfg_mode),
        .cfg_word_count (cfg_word_count),
        .psum_valid     (psum_valid),
        .psum_frame     (psum_frame),
        .dec_valid      (dec_valid),
        .dec_frame      (dec_frame),
        .dec_mode       (dec_mode),
        .word_limit     (word_limit),
        .cfg_clear      (cfg_clear)
    );

    psum_reduce_tree u_tree (
        .clk        (clk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .dec_frame  (dec_frame),
        .dec_mode   (dec_mode),
        .exe_valid  (exe_valid),
        .exe_sums   (exe_sums),
        .exe_mode   (exe_mode)
    );

    psum_pack_write u_pack (
        .clk        (clk),
        .reset      (reset),
        .exe_valid  (exe_valid),
        .exe_sums   (exe_sums),
        .exe_mode   (exe_mode),
        .word_limit (word_limit),
        .cfg_clear  (cfg_clear),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

`default_nettype wire

//--- source/psum_pack_write.sv
//--------------------------------------
// psum pack and write stage
// packs folded sums into 512-bit words, writes with a wrapping address
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "psum_reduce_params.svh"

module psum_pack_write (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             exe_valid,
    input  psum_reduce_pkg::row_sums_t       exe_sums,
    input  psum_reduce_pkg::fold_mode_e      exe_mode,
    input  psum_reduce_pkg::buf_addr_t       word_limit,
    input  logic                             cfg_clear,
    output logic                             wr_en,
    output psum_reduce_pkg::buf_addr_t       wr_addr,
    output psum_reduce_pkg::buf_word_t       wr_data
);

    localparam int POS_W = $clog2(`BUF_LANES) + 1;     // must hold the lane count itself

    typedef logic [POS_W-1:0] pos_t;

    pos_t                       fill_pos;   // next free lane
    pos_t                       per_frame;  // sums delivered by one frame
    pos_t                       fill_end;
    logic                       word_full;
    psum_reduce_pkg::buf_word_t word_q;
    psum_reduce_pkg::buf_word_t word_next;

    always_comb begin
        case (exe_mode)
            psum_reduce_pkg::fold_2: per_frame = pos_t'(`PSUM_ROWS / 2);
            psum_reduce_pkg::fold_4: per_frame = pos_t'(`PSUM_ROWS / 4);
            default:                 per_frame = pos_t'(`PSUM_ROWS);
        endcase
    end

    assign fill_end  = fill_pos + per_frame;
    assign word_full = (fill_end == pos_t'(`BUF_LANES));

    // drop this frame's sums into the word starting at fill_pos
    always_comb begin
        pos_t lane;
        word_next = word_q;
        for (int i = 0; i < `PSUM_ROWS; i++) begin
            lane = fill_pos + pos_t'(i);
            if (pos_t'(i) < per_frame && lane < pos_t'(`BUF_LANES))
                word_next[lane] = exe_sums[i];
        end
    end

    // word under construction, one update per frame
    always_ff @(posedge clk) begin
        if (exe_valid)
            word_q <= word_next;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en    <= 1'b0;
            fill_pos <= '0;
            wr_addr  <= '0;
        end else begin
            wr_en <= exe_valid && word_full && !cfg_clear;
            if (cfg_clear) begin
                fill_pos <= '0;     // partial word is discarded
                wr_addr  <= '0;
            end else begin
                if (exe_valid)
                    fill_pos <= word_full ? pos_t'(0) : fill_end;
                // step the address once the write has gone out
                if (wr_en)
                    wr_addr <= (wr_addr >= word_limit - 1'b1) ? '0 : wr_addr + 1'b1;
            end
        end
    end

    assign wr_data = word_q;

    // a mode change without a clear would misalign the fill position
    fill_in_range: assert property (@(posedge clk) disable iff (reset)
        exe_valid |-> fill_end <= pos_t'(`BUF_LANES));

    // limit comes from the decode stage's configuration
    addr_in_range: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> wr_addr < word_limit);

endmodule

`default_nettype wire

//--- source/psum_reduce_tree.sv
//--------------------------------------
// psum reduction tree
// row sums across columns, then folds of 2 or 4 rows
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "psum_reduce_params.svh"

module psum_reduce_tree (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             dec_valid,
    input  psum_reduce_pkg::psum_frame_t     dec_frame,
    input  psum_reduce_pkg::fold_mode_e      dec_mode,
    output logic                             exe_valid,
    output psum_reduce_pkg::row_sums_t       exe_sums,
    output psum_reduce_pkg::fold_mode_e      exe_mode
);

    psum_reduce_pkg::psum_t     row_sum  [`PSUM_ROWS];
    psum_reduce_pkg::psum_t     pair_sum [`PSUM_ROWS/2];
    psum_reduce_pkg::psum_t     quad_sum [`PSUM_ROWS/4];
    psum_reduce_pkg::row_sums_t sel_sums;

    // level 0: every row across all of its columns
    always_comb begin
        psum_reduce_pkg::psum_t acc;
        for (int r = 0; r < `PSUM_ROWS; r++) begin
            acc = '0;
            for (int c = 0; c < `PSUM_COLS; c++) begin
                acc = acc + dec_frame[r][c];    // wraps mod 2^16
            end
            row_sum[r] = acc;
        end
    end

    // level 1 and 2: adjacent rows carrying the irrelevant operand
    always_comb begin
        for (int j = 0; j < `PSUM_ROWS/2; j++) begin
            pair_sum[j] = row_sum[2*j] + row_sum[2*j+1];
        end
        for (int j = 0; j < `PSUM_ROWS/4; j++) begin
            quad_sum[j] = pair_sum[2*j] + pair_sum[2*j+1];
        end
    end

    // pick the level for this frame, packed from lane 0
    always_comb begin
        sel_sums = '0;
        case (dec_mode)
            psum_reduce_pkg::fold_2: begin
                for (int j = 0; j < `PSUM_ROWS/2; j++) begin
                    sel_sums[j] = pair_sum[j];
                end
            end
            psum_reduce_pkg::fold_4: begin
                for (int j = 0; j < `PSUM_ROWS/4; j++) begin
                    sel_sums[j] = quad_sum[j];
                end
            end
            default: begin
                for (int r = 0; r < `PSUM_ROWS; r++) begin
                    sel_sums[r] = row_sum[r];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
            exe_mode  <= psum_reduce_pkg::fold_1;
        end else begin
            exe_valid <= dec_valid;
            if (dec_valid)
                exe_mode <= dec_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid)
            exe_sums <= sel_sums;
    end

    // sums handed to the result stage are fully defined
    exe_sums_known: assert property (@(posedge clk) disable iff (reset)
        exe_valid |-> !$isunknown(exe_sums));

endmodule

`default_nettype wire

//--- source/psum_decode.sv
//--------------------------------------
// psum decode stage
// holds configuration, registers frames tagged with the fold mode
//--------------------------------------
`timescale 1ns/10ps
`default_nettype none

module psum_decode (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cfg_valid,
    input  psum_reduce_pkg::fold_mode_e      cfg_mode,
    input  psum_reduce_pkg::buf_addr_t       cfg_word_count,
    input  logic                             psum_valid,
    input  psum_reduce_pkg::psum_frame_t     psum_frame,
    output logic                             dec_valid,
    output psum_reduce_pkg::psum_frame_t     dec_frame,
    output psum_reduce_pkg::fold_mode_e      dec_mode,
    output psum_reduce_pkg::buf_addr_t       word_limit,
    output logic                             cfg_clear
);

    psum_reduce_pkg::fold_mode_e active_mode;

    // configuration registers
    always_ff @(posedge clk) begin
        if (reset) begin
            active_mode <= psum_reduce_pkg::fold_1;
            word_limit  <= psum_reduce_pkg::buf_addr_t'(1);
            cfg_clear   <= 1'b0;
        end else begin
            cfg_clear <= cfg_valid;     // tells the result stage to drop its partial word
            if (cfg_valid) begin
                active_mode <= cfg_mode;
                word_limit  <= cfg_word_count;
            end
        end
    end

    // frame pipeline register
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_mode  <= psum_reduce_pkg::fold_1;
        end else begin
            dec_valid <= psum_valid;
            if (psum_valid)
                dec_mode <= active_mode;    // mode in force when the frame arrived
        end
    end

    always_ff @(posedge clk) begin
        if (psum_valid)
            dec_frame <= psum_frame;
    end

    // only the three supported folds are legal
    cfg_mode_legal: assert property (@(posedge clk) disable iff (reset)
        cfg_valid |-> cfg_mode inside {psum_reduce_pkg::fold_1, psum_reduce_pkg::fold_2,
                                       psum_reduce_pkg::fold_4});

    cfg_count_nonzero: assert property (@(posedge clk) disable iff (reset)
        cfg_valid |-> cfg_word_count != '0);

    // the pipeline must be drained before a reconfiguration, otherwise
    // frames in flight would land in the cleared word
    cfg_pipe_idle: assert property (@(posedge clk) disable iff (reset)
        cfg_valid |-> !psum_valid && !$past(psum_valid, 1) && !$past(psum_valid, 2)
                      && !$past(psum_valid, 3));

endmodule

`default_nettype wire

//--- source/psum_reduce_pkg.sv
//--------------------------------------
// psum reduction types
// fold modes, frame, row sum and buffer word layouts
//--------------------------------------
`default_nettype none

`include "psum_reduce_params.svh"

package psum_reduce_pkg;

    // how many adjacent rows share one output
    typedef enum logic [1:0] {
        fold_1 = 2'd0,
        fold_2 = 2'd1,
        fold_4 = 2'd2
    } fold_mode_e;

    typedef logic [`PSUM_WIDTH-1:0] psum_t;

    // element (r, c) sits at position r*cols + c counted from the msb
    typedef psum_t [0:`PSUM_ROWS-1][0:`PSUM_COLS-1] psum_frame_t;

    // folded sums, left-packed, unused tail is zero
    typedef psum_t [0:`PSUM_ROWS-1] row_sums_t;

    // lane 0 occupies the top 16 bits
    typedef psum_t [0:`BUF_LANES-1] buf_word_t;

    typedef logic [`BUF_ADDR_WIDTH-1:0] buf_addr_t;

endpackage

`default_nettype wire

//--- source/psum_reduce_params.svh
//--------------------------------------
// psum reduction sizes
// frame geometry and psum buffer word layout
//--------------------------------------
`ifndef PSUM_REDUCE_PARAMS_SVH
`define PSUM_REDUCE_PARAMS_SVH

// pe array frame
`define PSUM_ROWS 16
`define PSUM_COLS 16

// bits per partial sum, all arithmetic wraps at this width
`define PSUM_WIDTH 16

// psum buffer side
`define BUF_WORD_WIDTH 512
`define BUF_LANES (`BUF_WORD_WIDTH / `PSUM_WIDTH)   // 32 lanes per word
`define BUF_ADDR_WIDTH 10

`endif
